//--- design/rob_defines.svh
// reorder buffer sizing and instruction-type codes
// ROB_DEPTH must stay a power of two and ROB_IDX_W its log2
// COMMIT_WIDTH is fixed at 2, the commit mask rules assume two slots
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// ========================================
// sizing
// ========================================
`define ROB_DEPTH     16
`define ROB_IDX_W     4
`define DECODE_WIDTH  2
`define COMMIT_WIDTH  2

// ========================================
// instruction types, 2 bits each
// ========================================
`define ITYPE_ALU    2'd0
`define ITYPE_BR     2'd1
`define ITYPE_LOAD   2'd2
`define ITYPE_STORE  2'd3

`endif

//--- design/rob_pkg.sv
// shared types of the reorder buffer
// widths come from rob_defines.svh, per-slot fields are packed arrays
// indexed by decode or commit slot
`include "rob_defines.svh"

package rob_pkg;

  // ========================================
  // plain vectors
  // ========================================
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
  // wrap bit on top of the index
  typedef logic [`ROB_IDX_W:0]   rob_ptr_t;
  // occupancy, 0 to ROB_DEPTH
  typedef logic [`ROB_IDX_W:0]   rob_cnt_t;
  typedef logic [31:0]           pc_t;
  typedef logic [4:0]            areg_t;
  typedef logic [5:0]            preg_t;
  typedef logic [1:0]            itype_t;

  // ========================================
  // decode side
  // ========================================
  typedef struct packed {
    logic   [`DECODE_WIDTH-1:0] valid;
    pc_t    [`DECODE_WIDTH-1:0] pc;
    itype_t [`DECODE_WIDTH-1:0] itype;
    areg_t  [`DECODE_WIDTH-1:0] areg;
    preg_t  [`DECODE_WIDTH-1:0] preg;
    preg_t  [`DECODE_WIDTH-1:0] old_preg;
    // exception found at decode
    logic   [`DECODE_WIDTH-1:0] exc;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                         ready;
    rob_idx_t [`DECODE_WIDTH-1:0] idx;
    logic     [`DECODE_WIDTH-1:0] wrap;
  } rob_alloc_rsp_t;

  // ========================================
  // write-back
  // ========================================
  typedef struct packed {
    logic     valid;
    rob_idx_t idx;
    logic     redirect;
  } rob_wb_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t idx;
    logic     is_load;
    logic     exc;
  } rob_mem_wb_t;

  // ========================================
  // entry and commit
  // ========================================
  typedef struct packed {
    logic   complete;
    logic   exc;
    logic   redirect;
    pc_t    pc;
    itype_t itype;
    areg_t  areg;
    preg_t  preg;
    preg_t  old_preg;
  } rob_entry_t;

  typedef struct packed {
    logic       [`COMMIT_WIDTH-1:0] valid;
    rob_entry_t [`COMMIT_WIDTH-1:0] entry;
  } rob_cmt_t;

  typedef struct packed {
    logic valid;
    pc_t  pc;
    // 1 for exception, 0 for branch redirect
    logic is_exc;
  } rob_redirect_t;

endpackage

//--- design/rob_ctrl.sv
// head, tail and occupancy of the reorder buffer
// allocation is all or nothing per cycle, ready needs room for a full
// decode group; valid slots must be packed from slot 0
// flush drops any allocation of the same cycle
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rob_pkg::rob_alloc_req_t alloc_req,
  output rob_pkg::rob_alloc_rsp_t alloc_rsp,
  output logic                    alloc_fire,
  input  logic [1:0]              commit_cnt,
  input  logic                    flush,
  output rob_pkg::rob_ptr_t       head,
  output rob_pkg::rob_ptr_t       tail,
  output rob_pkg::rob_cnt_t       occupancy
);

  // ========================================
  // signals
  // ========================================
  logic [1:0]        alloc_cnt;
  rob_pkg::rob_ptr_t alloc_add;
  rob_pkg::rob_ptr_t cmt_add;
  rob_pkg::rob_ptr_t slot_ptr [`DECODE_WIDTH];

  // ========================================
  // allocation side
  // ========================================
  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_cnt = alloc_cnt + 2'(alloc_req.valid[i]);
    end
  end

  assign alloc_rsp.ready =
    occupancy <= rob_pkg::rob_cnt_t'(`ROB_DEPTH - `DECODE_WIDTH);

  // a redirect at the same edge wins over new entries
  assign alloc_fire = alloc_rsp.ready & ~flush;

  // indices offered to decode every cycle, straight from the tail
  always_comb begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      slot_ptr[i]       = tail + rob_pkg::rob_ptr_t'(i);
      alloc_rsp.idx[i]  = slot_ptr[i][`ROB_IDX_W-1:0];
      alloc_rsp.wrap[i] = slot_ptr[i][`ROB_IDX_W];
    end
  end

  assign alloc_add = alloc_fire ? rob_pkg::rob_ptr_t'(alloc_cnt) : '0;
  assign cmt_add   = rob_pkg::rob_ptr_t'(commit_cnt);

  // ========================================
  // pointer registers
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      occupancy <= '0;
    end else if (flush) begin
      head      <= '0;
      tail      <= '0;
      occupancy <= '0;
    end else begin
      head      <= head + cmt_add;
      tail      <= tail + alloc_add;
      // pointer and count widths are equal
      occupancy <= occupancy + alloc_add - cmt_add;
    end
  end

endmodule

//--- design/rob_entry_array.sv
// reorder buffer entry storage
// payload fields are only meaningful while the entry is live
// a non-load memory write-back waits until its entry is at the head
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_entry_array (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rob_pkg::rob_alloc_req_t alloc_req,
  input  logic                    alloc_fire,
  input  rob_pkg::rob_ptr_t       tail,
  input  rob_pkg::rob_ptr_t       head,
  input  rob_pkg::rob_wb_t  [1:0] alu_wb,
  input  rob_pkg::rob_mem_wb_t    mem_wb,
  output logic                    mem_wb_ready,
  output rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entries
);

  // ========================================
  // storage
  // ========================================
  logic [`ROB_DEPTH-1:0] complete_q;
  logic [`ROB_DEPTH-1:0] exc_q;
  logic [`ROB_DEPTH-1:0] redir_q;

  rob_pkg::pc_t    pc_q       [`ROB_DEPTH];
  rob_pkg::itype_t itype_q    [`ROB_DEPTH];
  rob_pkg::areg_t  areg_q     [`ROB_DEPTH];
  rob_pkg::preg_t  preg_q     [`ROB_DEPTH];
  rob_pkg::preg_t  old_preg_q [`ROB_DEPTH];

  rob_pkg::rob_idx_t [`DECODE_WIDTH-1:0] alloc_idx;
  rob_pkg::rob_idx_t [`COMMIT_WIDTH-1:0] rd_idx;
  logic                                  mem_accept;

  always_comb begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_idx[i] = tail[`ROB_IDX_W-1:0] + rob_pkg::rob_idx_t'(i);
    end
  end

  // loads may complete anywhere and everything else only as oldest
  assign mem_wb_ready = mem_wb.is_load | (mem_wb.idx == head[`ROB_IDX_W-1:0]);
  assign mem_accept   = mem_wb.valid & mem_wb_ready;

  // ========================================
  // status flags
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      complete_q <= '0;
      exc_q      <= '0;
      redir_q    <= '0;
    end else begin
      if (alloc_fire) begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
          if (alloc_req.valid[i]) begin
            // decode exception leaves nothing to execute
            complete_q[alloc_idx[i]] <= alloc_req.exc[i];
            exc_q[alloc_idx[i]]      <= alloc_req.exc[i];
            redir_q[alloc_idx[i]]    <= 1'b0;
          end
        end
      end
      for (int j = 0; j < 2; j++) begin
        if (alu_wb[j].valid) begin
          complete_q[alu_wb[j].idx] <= 1'b1;
          redir_q[alu_wb[j].idx]    <= alu_wb[j].redirect;
        end
      end
      if (mem_accept) begin
        complete_q[mem_wb.idx] <= 1'b1;
        exc_q[mem_wb.idx]      <= mem_wb.exc;
      end
    end
  end

  // payload written once at allocation
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        if (alloc_req.valid[i]) begin
          pc_q[alloc_idx[i]]       <= alloc_req.pc[i];
          itype_q[alloc_idx[i]]    <= alloc_req.itype[i];
          areg_q[alloc_idx[i]]     <= alloc_req.areg[i];
          preg_q[alloc_idx[i]]     <= alloc_req.preg[i];
          old_preg_q[alloc_idx[i]] <= alloc_req.old_preg[i];
        end
      end
    end
  end

  // ========================================
  // head read ports
  // ========================================
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      rd_idx[i] = head[`ROB_IDX_W-1:0] + rob_pkg::rob_idx_t'(i);
      head_entries[i].complete = complete_q[rd_idx[i]];
      head_entries[i].exc      = exc_q[rd_idx[i]];
      head_entries[i].redirect = redir_q[rd_idx[i]];
      head_entries[i].pc       = pc_q[rd_idx[i]];
      head_entries[i].itype    = itype_q[rd_idx[i]];
      head_entries[i].areg     = areg_q[rd_idx[i]];
      head_entries[i].preg     = preg_q[rd_idx[i]];
      head_entries[i].old_preg = old_preg_q[rd_idx[i]];
    end
  end

endmodule

//--- design/rob_commit.sv
// in-order retirement of up to two entries per cycle
// purely combinational from the head entries and occupancy
// slot 1 is held back behind an exception, a redirect or a branch,
// so a redirect always comes from the last committing slot
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_commit (
  input  rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entries,
  input  rob_pkg::rob_cnt_t                       occupancy,
  output rob_pkg::rob_cmt_t                       cmt,
  output logic [1:0]                              commit_cnt,
  output rob_pkg::rob_redirect_t                  redirect,
  output logic                                    flush
);

  // ========================================
  // masks
  // ========================================
  // entry is live in the buffer
  logic [`COMMIT_WIDTH-1:0] valid_mask;
  // nothing retires behind a redirect
  logic [`COMMIT_WIDTH-1:0] redirect_mask;
  // nothing retires behind an exception
  logic [`COMMIT_WIDTH-1:0] exc_mask;
  // predictor takes one update per cycle
  logic [`COMMIT_WIDTH-1:0] br_mask;
  logic [`COMMIT_WIDTH-1:0] commit_mask;
  logic [`COMMIT_WIDTH-1:0] commit_valid;

  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      valid_mask[i] = occupancy > rob_pkg::rob_cnt_t'(i);
    end

    // oldest entry is never masked
    redirect_mask[0] = 1'b1;
    exc_mask[0]      = 1'b1;
    br_mask[0]       = 1'b1;

    // second slot retires only if both entries are plain
    redirect_mask[1] = ~head_entries[0].redirect & ~head_entries[1].redirect;
    exc_mask[1]      = ~head_entries[0].exc & ~head_entries[1].exc;
    br_mask[1]       = head_entries[0].itype != `ITYPE_BR;

    commit_mask = redirect_mask & exc_mask & br_mask;
  end

  // ========================================
  // commit valid and count
  // ========================================
  always_comb begin
    commit_valid[0] = head_entries[0].complete & commit_mask[0] & valid_mask[0];
    // strictly in order, slot 1 needs slot 0
    commit_valid[1] = commit_valid[0] & head_entries[1].complete &
                      commit_mask[1] & valid_mask[1];
  end

  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      commit_cnt = commit_cnt + 2'(commit_valid[i]);
    end
  end

  assign cmt.valid = commit_valid;
  assign cmt.entry = head_entries;

  // ========================================
  // redirect and flush
  // ========================================
  always_comb begin
    redirect.valid  = 1'b0;
    redirect.pc     = '0;
    redirect.is_exc = 1'b0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_valid[i] && (head_entries[i].exc || head_entries[i].redirect)) begin
        redirect.valid  = 1'b1;
        redirect.pc     = head_entries[i].pc;
        // exception takes precedence when both are set
        redirect.is_exc = head_entries[i].exc;
      end
    end
  end

  // buffer empties at the same edge the redirect retires
  assign flush = redirect.valid;

endmodule

//--- design/rob_top.sv
// reorder buffer top: pointer control, entry storage and commit logic
// two ALU write-back strobes without back-pressure, one memory port
// with a ready that the producer must honour
// cmt and redirect are strobes, the consumer cannot stall them
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // decode
  input  rob_pkg::rob_alloc_req_t alloc_req,
  output rob_pkg::rob_alloc_rsp_t alloc_rsp,
  // write-back
  input  rob_pkg::rob_wb_t  [1:0] alu_wb,
  input  rob_pkg::rob_mem_wb_t    mem_wb,
  output logic                    mem_wb_ready,
  // retirement
  output rob_pkg::rob_cmt_t       cmt,
  output rob_pkg::rob_redirect_t  redirect
);

  // ========================================
  // internal wires
  // ========================================
  logic                                   alloc_fire;
  logic [1:0]                             commit_cnt;
  logic                                   flush;
  rob_pkg::rob_ptr_t                      head;
  rob_pkg::rob_ptr_t                      tail;
  rob_pkg::rob_cnt_t                      occupancy;
  rob_pkg::rob_entry_t [`COMMIT_WIDTH-1:0] head_entries;

  rob_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .alloc_fire (alloc_fire),
    .commit_cnt (commit_cnt),
    .flush      (flush),
    .head       (head),
    .tail       (tail),
    .occupancy  (occupancy)
  );

  rob_entry_array u_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_req    (alloc_req),
    .alloc_fire   (alloc_fire),
    .tail         (tail),
    .head         (head),
    .alu_wb       (alu_wb),
    .mem_wb       (mem_wb),
    .mem_wb_ready (mem_wb_ready),
    .head_entries (head_entries)
  );

  rob_commit u_commit (
    .head_entries (head_entries),
    .occupancy    (occupancy),
    .cmt          (cmt),
    .commit_cnt   (commit_cnt),
    .redirect     (redirect),
    .flush        (flush)
  );

endmodule

//--- dv/rob_tb.sv
// table-driven testbench for rob_top
// each table row is one clock cycle of stimulus plus hand-derived expectations
// inputs change on the rising edge and outputs are sampled on the falling edge
// expected pcs follow the pcs given to allocation in the same table
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_tb;

  localparam int N_ROWS    = 35;
  localparam int MAX_CYCLE = N_ROWS + 20;

  typedef struct packed {
    rob_pkg::rob_alloc_req_t alloc;
    rob_pkg::rob_wb_t [1:0]  alu;
    rob_pkg::rob_mem_wb_t    mem;
    logic                    chk_alloc;
    logic                    exp_ready;
    rob_pkg::rob_idx_t       exp_idx0;
    logic                    exp_wrap0;
    rob_pkg::rob_idx_t       exp_idx1;
    logic                    exp_wrap1;
    logic                    chk_mem;
    logic                    exp_mem_ready;
    logic [1:0]              exp_cmt;
    rob_pkg::pc_t            exp_pc0;
    rob_pkg::pc_t            exp_pc1;
    logic                    exp_redir;
    rob_pkg::pc_t            exp_redir_pc;
    logic                    exp_is_exc;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  rob_pkg::rob_alloc_req_t alloc_req;
  rob_pkg::rob_alloc_rsp_t alloc_rsp;
  rob_pkg::rob_wb_t [1:0]  alu_wb;
  rob_pkg::rob_mem_wb_t    mem_wb;
  logic                    mem_wb_ready;
  rob_pkg::rob_cmt_t       cmt;
  rob_pkg::rob_redirect_t  redirect;

  row_t rows [N_ROWS];
  int   cycles;

  rob_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_req    (alloc_req),
    .alloc_rsp    (alloc_rsp),
    .alu_wb       (alu_wb),
    .mem_wb       (mem_wb),
    .mem_wb_ready (mem_wb_ready),
    .cmt          (cmt),
    .redirect     (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // register payload per pc
  // ========================================
  // each entry carries registers tied to its own pc
  function automatic logic [4:0] areg_for(input logic [31:0] pc);
    return pc[6:2];
  endfunction

  function automatic logic [5:0] preg_for(input logic [31:0] pc);
    return {1'b1, pc[6:2]};
  endfunction

  function automatic logic [5:0] old_preg_for(input logic [31:0] pc);
    return {1'b0, ~pc[6:2]};
  endfunction

  // ========================================
  // table building helpers
  // ========================================
  task automatic alloc_pair(input int n, input logic [31:0] pc0, input logic [1:0] it0,
                            input logic exc0, input logic [31:0] pc1,
                            input logic [1:0] it1, input logic exc1);
    rows[n].alloc.valid       = 2'b11;
    rows[n].alloc.pc[0]       = pc0;
    rows[n].alloc.pc[1]       = pc1;
    rows[n].alloc.itype[0]    = it0;
    rows[n].alloc.itype[1]    = it1;
    rows[n].alloc.exc[0]      = exc0;
    rows[n].alloc.exc[1]      = exc1;
    rows[n].alloc.areg[0]     = areg_for(pc0);
    rows[n].alloc.areg[1]     = areg_for(pc1);
    rows[n].alloc.preg[0]     = preg_for(pc0);
    rows[n].alloc.preg[1]     = preg_for(pc1);
    rows[n].alloc.old_preg[0] = old_preg_for(pc0);
    rows[n].alloc.old_preg[1] = old_preg_for(pc1);
  endtask

  task automatic alloc_one(input int n, input logic [31:0] pc0, input logic [1:0] it0);
    rows[n].alloc.valid       = 2'b01;
    rows[n].alloc.pc[0]       = pc0;
    rows[n].alloc.itype[0]    = it0;
    rows[n].alloc.areg[0]     = areg_for(pc0);
    rows[n].alloc.preg[0]     = preg_for(pc0);
    rows[n].alloc.old_preg[0] = old_preg_for(pc0);
  endtask

  task automatic alu_done(input int n, input int port, input logic [3:0] idx,
                          input logic redir);
    rows[n].alu[port].valid    = 1'b1;
    rows[n].alu[port].idx      = idx;
    rows[n].alu[port].redirect = redir;
  endtask

  task automatic mem_req(input int n, input logic [3:0] idx, input logic is_load,
                         input logic exp_rdy);
    rows[n].mem.valid     = 1'b1;
    rows[n].mem.idx       = idx;
    rows[n].mem.is_load   = is_load;
    rows[n].chk_mem       = 1'b1;
    rows[n].exp_mem_ready = exp_rdy;
  endtask

  task automatic expect_alloc(input int n, input logic rdy, input int idx0);
    rows[n].chk_alloc = 1'b1;
    rows[n].exp_ready = rdy;
    rows[n].exp_idx0  = 4'(idx0 % 16);
    rows[n].exp_wrap0 = (idx0 % 32) >= 16;
    rows[n].exp_idx1  = 4'((idx0 + 1) % 16);
    rows[n].exp_wrap1 = ((idx0 + 1) % 32) >= 16;
  endtask

  task automatic expect_commit(input int n, input logic [1:0] mask,
                               input logic [31:0] pc0, input logic [31:0] pc1);
    rows[n].exp_cmt = mask;
    rows[n].exp_pc0 = pc0;
    rows[n].exp_pc1 = pc1;
  endtask

  task automatic expect_redirect(input int n, input logic [31:0] pc, input logic is_exc);
    rows[n].exp_redir    = 1'b1;
    rows[n].exp_redir_pc = pc;
    rows[n].exp_is_exc   = is_exc;
  endtask

  // ========================================
  // stimulus table
  // ========================================
  task automatic build_table();
    for (int n = 0; n < N_ROWS; n++) begin
      rows[n] = '0;
    end
    // ordered allocation, out-of-order completion, paired commit
    alloc_pair(0, 'h100, `ITYPE_ALU, 0, 'h104, `ITYPE_ALU, 0);
    expect_alloc(0, 1, 0);
    alloc_pair(1, 'h108, `ITYPE_ALU, 0, 'h10c, `ITYPE_ALU, 0);
    expect_alloc(1, 1, 2);
    alu_done(1, 0, 1, 0);
    alu_done(2, 0, 0, 0);
    expect_alloc(2, 1, 4);
    expect_commit(3, 2'b11, 'h100, 'h104);
    alu_done(3, 0, 3, 0);
    alu_done(3, 1, 2, 0);
    expect_commit(4, 2'b11, 'h108, 'h10c);
    // branch at head retires alone
    alloc_pair(5, 'h110, `ITYPE_BR, 0, 'h114, `ITYPE_ALU, 0);
    expect_alloc(5, 1, 4);
    alu_done(6, 0, 4, 0);
    alu_done(6, 1, 5, 0);
    expect_commit(7, 2'b01, 'h110, 0);
    expect_commit(8, 2'b01, 'h114, 0);
    // store waits for the head while loads go anywhere
    alloc_pair(9, 'h118, `ITYPE_ALU, 0, 'h11c, `ITYPE_STORE, 0);
    expect_alloc(9, 1, 6);
    mem_req(10, 7, 0, 0);
    alloc_pair(10, 'h120, `ITYPE_LOAD, 0, 'h124, `ITYPE_ALU, 0);
    expect_alloc(10, 1, 8);
    mem_req(11, 7, 0, 0);
    alu_done(11, 0, 6, 0);
    mem_req(12, 7, 0, 0);
    expect_commit(12, 2'b01, 'h118, 0);
    mem_req(13, 7, 0, 1);
    mem_req(14, 9, 1, 1);
    expect_commit(14, 2'b01, 'h11c, 0);
    mem_req(15, 8, 1, 1);
    expect_commit(16, 2'b11, 'h120, 'h124);
    // fill to 15 entries while the tail wraps past index 15
    for (int k = 0; k < 7; k++) begin
      alloc_pair(17 + k, 'h200 + 8 * k, `ITYPE_ALU, 0, 'h204 + 8 * k, `ITYPE_ALU, 0);
      expect_alloc(17 + k, 1, 10 + 2 * k);
    end
    alloc_one(24, 'h238, `ITYPE_ALU);
    expect_alloc(24, 1, 24);
    alloc_pair(25, 'h240, `ITYPE_ALU, 0, 'h244, `ITYPE_ALU, 0);
    expect_alloc(25, 0, 25);
    alu_done(25, 0, 10, 0);
    alu_done(25, 1, 11, 0);
    alloc_pair(26, 'h240, `ITYPE_ALU, 0, 'h244, `ITYPE_ALU, 0);
    expect_alloc(26, 0, 25);
    expect_commit(26, 2'b11, 'h200, 'h204);
    expect_alloc(27, 1, 25);
    // branch redirect at head flushes and holds back a completed entry behind it
    alu_done(27, 0, 12, 1);
    alu_done(27, 1, 13, 0);
    alloc_pair(28, 'h250, `ITYPE_ALU, 0, 'h254, `ITYPE_ALU, 0);
    expect_alloc(28, 1, 25);
    expect_commit(28, 2'b01, 'h208, 0);
    expect_redirect(28, 'h208, 0);
    // decode exception retires alone and flushes
    alloc_pair(29, 'h300, `ITYPE_ALU, 0, 'h304, `ITYPE_ALU, 1);
    expect_alloc(29, 1, 0);
    alu_done(30, 0, 0, 0);
    expect_alloc(30, 1, 2);
    expect_commit(31, 2'b01, 'h300, 0);
    expect_commit(32, 2'b01, 'h304, 0);
    expect_redirect(32, 'h304, 1);
    alloc_pair(33, 'h308, `ITYPE_ALU, 0, 'h30c, `ITYPE_ALU, 0);
    expect_alloc(33, 1, 0);
    expect_alloc(34, 1, 2);
  endtask

  // ========================================
  // checking
  // ========================================
  task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                           input int n, input string what);
    assert (got === exp) else begin
      $display("ERR %0t ns: row %0d %s is %h, expected %h", $time, n, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic check_commit_slot(input int n, input int s, input logic [31:0] pc);
    rob_pkg::rob_entry_t e;
    e = cmt.entry[s];
    check_val(e.pc, pc, n, $sformatf("commit slot %0d pc", s));
    check_val(32'(e.areg), 32'(areg_for(pc)), n, $sformatf("commit slot %0d areg", s));
    check_val(32'(e.preg), 32'(preg_for(pc)), n, $sformatf("commit slot %0d preg", s));
    check_val(32'(e.old_preg), 32'(old_preg_for(pc)), n,
              $sformatf("commit slot %0d old preg", s));
  endtask

  task automatic check_row(input int n);
    if (rows[n].chk_alloc) begin
      check_val(32'(alloc_rsp.ready), 32'(rows[n].exp_ready), n, "alloc ready");
      check_val(32'(alloc_rsp.idx[0]), 32'(rows[n].exp_idx0), n, "slot 0 index");
      check_val(32'(alloc_rsp.wrap[0]), 32'(rows[n].exp_wrap0), n, "slot 0 wrap");
      check_val(32'(alloc_rsp.idx[1]), 32'(rows[n].exp_idx1), n, "slot 1 index");
      check_val(32'(alloc_rsp.wrap[1]), 32'(rows[n].exp_wrap1), n, "slot 1 wrap");
    end
    if (rows[n].chk_mem) begin
      check_val(32'(mem_wb_ready), 32'(rows[n].exp_mem_ready), n, "mem_wb_ready");
    end
    check_val(32'(cmt.valid), 32'(rows[n].exp_cmt), n, "commit mask");
    if (rows[n].exp_cmt[0]) begin
      check_commit_slot(n, 0, rows[n].exp_pc0);
    end
    if (rows[n].exp_cmt[1]) begin
      check_commit_slot(n, 1, rows[n].exp_pc1);
    end
    check_val(32'(redirect.valid), 32'(rows[n].exp_redir), n, "redirect valid");
    if (rows[n].exp_redir) begin
      check_val(redirect.pc, rows[n].exp_redir_pc, n, "redirect pc");
      check_val(32'(redirect.is_exc), 32'(rows[n].exp_is_exc), n, "redirect kind");
    end
  endtask

  // ========================================
  // watchdog
  // ========================================
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLE) begin
        $display("timeout: the table did not finish within %0d cycles", MAX_CYCLE);
        $display("** FAIL **");
        $fatal(1, "timeout");
      end
    end
  end

  // ========================================
  // main sequence
  // ========================================
  initial begin
    rst_n     = 1'b0;
    alloc_req = '0;
    alu_wb    = '0;
    mem_wb    = '0;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge clk);
      alloc_req <= rows[i].alloc;
      alu_wb    <= rows[i].alu;
      mem_wb    <= rows[i].mem;
      @(negedge clk);
      check_row(i);
    end
    @(posedge clk);
    alloc_req <= '0;
    alu_wb    <= '0;
    mem_wb    <= '0;
    $display("** PASS **");
    $finish;
  end

endmodule

//--- project.f
+incdir+design
design/rob_pkg.sv
design/rob_ctrl.sv
design/rob_entry_array.sv
design/rob_commit.sv
design/rob_top.sv
dv/rob_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator and runs it
# a failing check ends the simulation with a non-zero exit status
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module rob_tb -f project.f

./obj_dir/Vrob_tb
